// File: decoder.f
hw/decoder_pkg.sv
hw/decoder_regs.sv
hw/biphase_to_nrz.sv
hw/mrk_spc_decode.sv
hw/iq_demux.sv
hw/output_format.sv
hw/decoder.sv
testbench/decoder_props.sv
testbench/decoder_tb.sv

// File: hw/biphase_to_nrz.sv
// biphase-L on the I stream only; half-bit phase restarts at reset and when biphase drops
`default_nettype none

module biphase_to_nrz (
  input  wire  clk,
  input  wire  rs,
  input  wire  symb_clk_en_i,
  input  wire  biphase_i,
  input  wire  symb_i_i,
  output logic nrz_i_o,
  output logic bit_en_o
);

  // -------------------------------------------------------------------
  // half-bit phase
  // -------------------------------------------------------------------

  // 0 before the first half, 1 before the second half
  logic half_q;
  // first half of the current biphase bit
  logic first_q;

  always_ff @(posedge clk or posedge rs)
  begin
    if (rs)
    begin
      half_q <= 1'b0;
    end
    else if (!biphase_i)
    begin
      // held cleared so the next enable starts on a first half
      half_q <= 1'b0;
    end
    else if (symb_clk_en_i)
    begin
      half_q <= ~half_q;
    end
  end

  // level, qualified by the strobe downstream
  // always high outside biphase
  assign bit_en_o = !biphase_i || half_q;

  // -------------------------------------------------------------------
  // first-half capture and nrz output
  // -------------------------------------------------------------------

  always_ff @(posedge clk or posedge rs)
  begin
    if (rs)
    begin
      first_q <= 1'b0;
      nrz_i_o <= 1'b0;
    end
    else if (symb_clk_en_i)
    begin
      if (!biphase_i)
      begin
        // plain nrz, one strobe of delay
        nrz_i_o <= symb_i_i;
      end
      else if (!half_q)
      begin
        // keep first half for the next strobe
        first_q <= symb_i_i;
      end
      else
      begin
        // biphase-L carries the bit in its first half
        nrz_i_o <= first_q;
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/decoder.sv
// strobes must be one clock wide; every 2x strobe is accepted, no back-pressure
`default_nettype none

module decoder (
  input  wire         clk,
  input  wire         rs,
  // control bus
  input  wire         en_i,
  input  wire         wr0_i,
  input  wire         wr1_i,
  input  wire [12:0]  addr_i,
  input  wire [15:0]  din_i,
  output logic [15:0] dout_o,
  // symbol stream
  input  wire         symb_clk_en_i,
  input  wire         symb_clk_2x_en_i,
  input  wire         symb_i_i,
  input  wire         symb_q_i,
  output logic        dout_i_o,
  output logic        dout_q_o,
  output logic        cout_o,
  output logic        symb_clk_o,
  // fifo and clock controls
  output logic        fifo_rs_o,
  output logic        clk_inv_o,
  output logic        bypass_fifo_o
);

  decoder_pkg::ctrl_word_u ctrl;

  logic nrz_i;
  logic bit_en;
  logic nrz_q;
  logic nrz_last_i;
  logic nrz_last_q;
  logic dec_i;
  logic dec_q;
  logic sel_i;
  logic sel_q;
  logic shift_en;

  // -------------------------------------------------------------------
  // control register
  // -------------------------------------------------------------------

  decoder_regs u_regs (
    .clk    (clk),
    .rs     (rs),
    .en_i   (en_i),
    .wr0_i  (wr0_i),
    .wr1_i  (wr1_i),
    .addr_i (addr_i),
    .din_i  (din_i),
    .dout_o (dout_o),
    .ctrl_o (ctrl)
  );

  // passed straight out to the fifo and clock logic
  assign fifo_rs_o     = ctrl.fields.fifo_rs;
  assign clk_inv_o     = ctrl.fields.clk_inv;
  assign bypass_fifo_o = ctrl.fields.bypass_fifo;

  // -------------------------------------------------------------------
  // biphase conversion and Q alignment
  // -------------------------------------------------------------------

  // one strobe of delay on I
  biphase_to_nrz u_b2n (
    .clk           (clk),
    .rs            (rs),
    .symb_clk_en_i (symb_clk_en_i),
    .biphase_i     (ctrl.fields.biphase),
    .symb_i_i      (symb_i_i),
    .nrz_i_o       (nrz_i),
    .bit_en_o      (bit_en)
  );

  // Q gets the same delay, plus previous bits for mark/space
  always_ff @(posedge clk or posedge rs)
  begin
    if (rs)
    begin
      nrz_q      <= 1'b0;
      nrz_last_i <= 1'b0;
      nrz_last_q <= 1'b0;
    end
    else if (symb_clk_en_i && bit_en)
    begin
      nrz_q      <= symb_q_i;
      nrz_last_i <= nrz_i;
      nrz_last_q <= nrz_q;
    end
  end

  // -------------------------------------------------------------------
  // mark/space decode
  // -------------------------------------------------------------------

  mrk_spc_decode u_msd_i (
    .clk        (clk),
    .rs         (rs),
    .clk_en_i   (symb_clk_en_i),
    .bit_en_i   (bit_en),
    .mode_i     (ctrl.fields.mode),
    .din_i      (nrz_i),
    .last_din_i (nrz_last_i),
    .dout_o     (dec_i)
  );

  mrk_spc_decode u_msd_q (
    .clk        (clk),
    .rs         (rs),
    .clk_en_i   (symb_clk_en_i),
    .bit_en_i   (bit_en),
    .mode_i     (ctrl.fields.mode),
    .din_i      (nrz_q),
    .last_din_i (nrz_last_q),
    .dout_o     (dec_q)
  );

  // -------------------------------------------------------------------
  // demux and output stage
  // -------------------------------------------------------------------

  iq_demux u_demux (
    .clk              (clk),
    .rs               (rs),
    .symb_clk_en_i    (symb_clk_en_i),
    .symb_clk_2x_en_i (symb_clk_2x_en_i),
    .demux_i          (ctrl.fields.demux),
    .feher_i          (ctrl.fields.feher),
    .swap_i           (ctrl.fields.swap),
    .dec_i_i          (dec_i),
    .dec_q_i          (dec_q),
    .sel_i_o          (sel_i),
    .sel_q_o          (sel_q),
    .shift_en_o       (shift_en)
  );

  output_format u_fmt (
    .clk              (clk),
    .rs               (rs),
    .shift_en_i       (shift_en),
    .symb_clk_en_i    (symb_clk_en_i),
    .symb_clk_2x_en_i (symb_clk_2x_en_i),
    .bit_en_i         (bit_en),
    .sel_i_i          (sel_i),
    .sel_q_i          (sel_q),
    .derandomize_i    (ctrl.fields.derandomize),
    .data_inv_i       (ctrl.fields.data_inv),
    .biphase_i        (ctrl.fields.biphase),
    .clk_sel_i        (ctrl.fields.clk_sel),
    .dout_i_o         (dout_i_o),
    .dout_q_o         (dout_q_o),
    .cout_o           (cout_o),
    .symb_clk_o       (symb_clk_o)
  );

endmodule

`default_nettype wire

// File: hw/decoder_pkg.sv
// one control register only; sign_mag bit is reserved and the three top bits are spare
`default_nettype none

package decoder_pkg;

  // -------------------------------------------------------------------
  // bus decode
  // -------------------------------------------------------------------

  // control register address on the parallel bus
  localparam logic [12:0] dec_ctrl_addr = 13'h0120;

  // control word width, written as two bytes
  localparam int dec_ctrl_w = 16;

  // -------------------------------------------------------------------
  // mark/space mode codes
  // -------------------------------------------------------------------

  // straight pass-through
  localparam logic [1:0] mode_nrz_l = 2'd0;
  // transition on a one
  localparam logic [1:0] mode_nrz_m = 2'd1;
  // transition on a zero; code 3 falls back to pass-through
  localparam logic [1:0] mode_nrz_s = 2'd2;

  // derandomizer length, taps at stages 15 and 14
  localparam int derand_len = 15;

  // -------------------------------------------------------------------
  // control word
  // -------------------------------------------------------------------

  // raw view for the bus, field view for the datapath
  typedef union packed {
    logic [dec_ctrl_w-1:0] raw;
    struct packed {
      logic [2:0] spare;
      logic       bypass_fifo;
      logic [1:0] mode;
      logic       sign_mag;
      logic       biphase;
      logic       swap;
      logic       feher;
      logic       demux;
      logic       derandomize;
      logic       data_inv;
      logic       clk_sel;
      logic       clk_inv;
      logic       fifo_rs;
    } fields;
  } ctrl_word_u;

endpackage

`default_nettype wire

// File: hw/decoder_regs.sv
// single 16-bit register; read data is zero unless en_i is high and the address matches
`default_nettype none

module decoder_regs (
  input  wire                     clk,
  input  wire                     rs,
  input  wire                     en_i,
  input  wire                     wr0_i,
  input  wire                     wr1_i,
  input  wire [12:0]              addr_i,
  input  wire [15:0]              din_i,
  output logic [15:0]             dout_o,
  output decoder_pkg::ctrl_word_u ctrl_o
);

  // -------------------------------------------------------------------
  // address decode
  // -------------------------------------------------------------------

  logic                   sel;
  decoder_pkg::ctrl_word_u ctrl_q;

  // bus cycle aimed at this register
  assign sel = en_i && (addr_i == decoder_pkg::dec_ctrl_addr);

  // -------------------------------------------------------------------
  // byte-strobed write
  // -------------------------------------------------------------------

  always_ff @(posedge clk or posedge rs)
  begin
    if (rs)
    begin
      ctrl_q.raw <= '0;
    end
    else if (sel)
    begin
      // low byte
      if (wr0_i)
      begin
        ctrl_q.raw[7:0] <= din_i[7:0];
      end
      // high byte
      if (wr1_i)
      begin
        ctrl_q.raw[decoder_pkg::dec_ctrl_w-1:8] <= din_i[15:8];
      end
    end
  end

  // -------------------------------------------------------------------
  // read-back and field output
  // -------------------------------------------------------------------

  // zero when not selected so several slaves can be or-ed
  assign dout_o = sel ? ctrl_q.raw : '0;

  assign ctrl_o = ctrl_q;

endmodule

`default_nettype wire

// File: hw/iq_demux.sv
// serial modes run on the 2x strobe; feher wins over demux when both are set
`default_nettype none

module iq_demux (
  input  wire  clk,
  input  wire  rs,
  input  wire  symb_clk_en_i,
  input  wire  symb_clk_2x_en_i,
  input  wire  demux_i,
  input  wire  feher_i,
  input  wire  swap_i,
  input  wire  dec_i_i,
  input  wire  dec_q_i,
  output logic sel_i_o,
  output logic sel_q_o,
  output logic shift_en_o
);

  // -------------------------------------------------------------------
  // 2x phase tracking
  // -------------------------------------------------------------------

  // set on the 2x strobe right after a coincident one
  logic phase_q;
  // I bit one 2x strobe back, for the fqpsk difference
  logic dly_i_q;
  logic serial;
  logic take_i;
  logic fqpsk_bit;
  logic serial_bit;

  assign serial = demux_i | feher_i;

  // swap reverses the I/Q order
  assign take_i = phase_q ^ swap_i;

  always_ff @(posedge clk or posedge rs)
  begin
    if (rs)
    begin
      phase_q <= 1'b0;
      dly_i_q <= 1'b0;
    end
    else if (symb_clk_2x_en_i)
    begin
      phase_q <= symb_clk_en_i;
      dly_i_q <= dec_i_i;
    end
  end

  // -------------------------------------------------------------------
  // serial bit forming
  // -------------------------------------------------------------------

  // differential bit, Q polarity flips with the phase
  assign fqpsk_bit = take_i ? (dly_i_q ^ dec_q_i) : (dly_i_q ^ ~dec_q_i);

  // qpsk/oqpsk just alternates the channels
  assign serial_bit = feher_i ? fqpsk_bit : (take_i ? dec_i_i : dec_q_i);

  // -------------------------------------------------------------------
  // output select register
  // -------------------------------------------------------------------

  always_ff @(posedge clk or posedge rs)
  begin
    if (rs)
    begin
      sel_i_o <= 1'b0;
      sel_q_o <= 1'b0;
    end
    else if (serial && symb_clk_2x_en_i)
    begin
      // single stream, Q carries the complement
      sel_i_o <= serial_bit;
      sel_q_o <= ~serial_bit;
    end
    else if (!serial && symb_clk_en_i)
    begin
      // parallel pair, optional swap
      sel_i_o <= swap_i ? dec_q_i : dec_i_i;
      sel_q_o <= swap_i ? dec_i_i : dec_q_i;
    end
  end

  // downstream shift follows the output rate
  assign shift_en_o = serial ? symb_clk_2x_en_i : symb_clk_en_i;

endmodule

`default_nettype wire

// File: hw/mrk_spc_decode.sv
// one channel; caller supplies the previous nrz bit, both enables must be high to update
`default_nettype none

module mrk_spc_decode (
  input  wire       clk,
  input  wire       rs,
  input  wire       clk_en_i,
  input  wire       bit_en_i,
  input  wire [1:0] mode_i,
  input  wire       din_i,
  input  wire       last_din_i,
  output logic      dout_o
);

  // -------------------------------------------------------------------
  // decode
  // -------------------------------------------------------------------

  logic diff;
  logic dec;

  // transition between adjacent bits
  assign diff = din_i ^ last_din_i;

  always_comb
  begin
    case (mode_i)
      decoder_pkg::mode_nrz_m:
      begin
        // mark, a change means one
        dec = diff;
      end
      decoder_pkg::mode_nrz_s:
      begin
        // space, a change means zero
        dec = ~diff;
      end
      default:
      begin
        // nrz-l and the unused code
        dec = din_i;
      end
    endcase
  end

  // decode register, one bit period
  always_ff @(posedge clk or posedge rs)
  begin
    if (rs)
    begin
      dout_o <= 1'b0;
    end
    else if (clk_en_i && bit_en_i)
    begin
      dout_o <= dec;
    end
  end

endmodule

`default_nettype wire

// File: hw/output_format.sv
// derandomized bit drives both outputs; cout_o is a one-clock pulse, not a square clock
`default_nettype none

module output_format (
  input  wire  clk,
  input  wire  rs,
  input  wire  shift_en_i,
  input  wire  symb_clk_en_i,
  input  wire  symb_clk_2x_en_i,
  input  wire  bit_en_i,
  input  wire  sel_i_i,
  input  wire  sel_q_i,
  input  wire  derandomize_i,
  input  wire  data_inv_i,
  input  wire  biphase_i,
  input  wire  clk_sel_i,
  output logic dout_i_o,
  output logic dout_q_o,
  output logic cout_o,
  output logic symb_clk_o
);

  // -------------------------------------------------------------------
  // self-synchronizing derandomizer
  // -------------------------------------------------------------------

  logic [decoder_pkg::derand_len-1:0] shift_q;
  logic                               derand_q;
  logic                               data_i;
  logic                               data_q;

  // received bits fill the line, syncs after derand_len bits
  always_ff @(posedge clk or posedge rs)
  begin
    if (rs)
    begin
      shift_q  <= '0;
      derand_q <= 1'b0;
    end
    else if (shift_en_i)
    begin
      shift_q  <= {shift_q[decoder_pkg::derand_len-2:0], sel_i_i};
      // taps 15 and 14
      derand_q <= sel_i_i ^ shift_q[decoder_pkg::derand_len-1]
                          ^ shift_q[decoder_pkg::derand_len-2];
    end
  end

  // -------------------------------------------------------------------
  // data select and inversion
  // -------------------------------------------------------------------

  assign data_i = derandomize_i ? derand_q : sel_i_i;
  assign data_q = derandomize_i ? derand_q : sel_q_i;

  assign dout_i_o = data_i ^ data_inv_i;
  assign dout_q_o = data_q ^ data_inv_i;

  // -------------------------------------------------------------------
  // clocks
  // -------------------------------------------------------------------

  // biphase gives one pulse per decoded bit
  assign cout_o = biphase_i ? (bit_en_i & symb_clk_en_i)
                            : (clk_sel_i ? symb_clk_en_i : symb_clk_2x_en_i);

  // high from each symbol strobe, low from the mid 2x strobe
  always_ff @(posedge clk or posedge rs)
  begin
    if (rs)
    begin
      symb_clk_o <= 1'b0;
    end
    else if (symb_clk_en_i)
    begin
      symb_clk_o <= 1'b1;
    end
    else if (symb_clk_2x_en_i)
    begin
      symb_clk_o <= ~symb_clk_o;
    end
  end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the decoder testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module decoder_tb \
  -f decoder.f \
  -o decoder_sim

output=$(./obj_dir/decoder_sim)
echo "$output"

if echo "$output" | grep -qx "Simulation PASSED"; then
  exit 0
else
  echo "run did not pass"
  exit 1
fi

// File: testbench/decoder_props.sv
// bound into decoder; needs the internal ctrl word, serial complement check skipped when derandomizing
`default_nettype none

module decoder_props (
  input wire                     clk,
  input wire                     rs,
  input wire                     symb_clk_en_i,
  input wire                     symb_clk_2x_en_i,
  input wire                     dout_i_o,
  input wire                     dout_q_o,
  input wire                     symb_clk_o,
  input wire                     fifo_rs_o,
  input wire                     clk_inv_o,
  input wire                     bypass_fifo_o,
  input wire decoder_pkg::ctrl_word_u ctrl
);

  // failures seen, read by the testbench summary
  int fail_cnt = 0;

  // serial stream without derandomizer, Q must mirror I
  logic serial_plain;

  assign serial_plain = (ctrl.fields.demux || ctrl.fields.feher) && !ctrl.fields.derandomize;

  // -------------------------------------------------------------------
  // reset values
  // -------------------------------------------------------------------

  reset_zero: assert property (@(posedge clk)
    rs |-> (!fifo_rs_o && !clk_inv_o && !bypass_fifo_o &&
            !dout_i_o && !dout_q_o && !symb_clk_o))
  else
  begin
    fail_cnt++;
    $error("control or data output not zero during reset");
  end

  // -------------------------------------------------------------------
  // serial modes
  // -------------------------------------------------------------------

  // one 2x strobe after entering serial mode the pair is complementary
  serial_compl: assert property (@(posedge clk) disable iff (rs)
    (serial_plain && symb_clk_2x_en_i) ##1 serial_plain |-> (dout_q_o != dout_i_o))
  else
  begin
    fail_cnt++;
    $error("dout_q_o is not the complement of dout_i_o in serial mode");
  end

  // -------------------------------------------------------------------
  // symbol clock
  // -------------------------------------------------------------------

  symb_clk_high: assert property (@(posedge clk) disable iff (rs)
    symb_clk_en_i |=> symb_clk_o)
  else
  begin
    fail_cnt++;
    $error("symb_clk_o low after a symbol strobe");
  end

endmodule

bind decoder decoder_props u_props (
  .clk              (clk),
  .rs               (rs),
  .symb_clk_en_i    (symb_clk_en_i),
  .symb_clk_2x_en_i (symb_clk_2x_en_i),
  .dout_i_o         (dout_i_o),
  .dout_q_o         (dout_q_o),
  .symb_clk_o       (symb_clk_o),
  .fifo_rs_o        (fifo_rs_o),
  .clk_inv_o        (clk_inv_o),
  .bypass_fifo_o    (bypass_fifo_o),
  .ctrl             (ctrl)
);

`default_nettype wire

// File: testbench/decoder_tb.sv
// symbol strobe every 8 clocks, 2x strobe every 4; bus writes only while strobes are idle
`default_nettype none

module decoder_tb;

  localparam int clk_period = 20;
  // nrz, biphase, qpsk, fqpsk, derandomize, inverted, clock select
  localparam int total_symbols = 60 + 20 + 12 + 12 + 40 + 12 + 4;
  // each symbol is two 2x strobes of 4 clocks, plus bus traffic margin
  localparam int timeout = total_symbols * 2 * 4 * clk_period + 200 * clk_period;

  // check kinds
  localparam int k_nrz = 0;
  localparam int k_bip = 1;
  localparam int k_qpsk = 2;
  localparam int k_fqpsk = 3;
  localparam int k_derand = 4;

  logic        clk;
  logic        rs;
  logic        en_i;
  logic        wr0_i;
  logic        wr1_i;
  logic [12:0] addr_i;
  logic [15:0] din_i;
  logic [15:0] dout_o;
  logic        symb_clk_en_i;
  logic        symb_clk_2x_en_i;
  logic        symb_i_i;
  logic        symb_q_i;
  logic        dout_i_o;
  logic        dout_q_o;
  logic        cout_o;
  logic        symb_clk_o;
  logic        fifo_rs_o;
  logic        clk_inv_o;
  logic        bypass_fifo_o;

  decoder_pkg::ctrl_word_u cfg;
  integer seed;
  int     errors;
  int     kind;
  int     cout_pulses;
  int     total_fail;
  logic   hist_i[$];
  logic   hist_q[$];
  logic   msg[$];

  decoder u_dut (
    .clk              (clk),
    .rs               (rs),
    .en_i             (en_i),
    .wr0_i            (wr0_i),
    .wr1_i            (wr1_i),
    .addr_i           (addr_i),
    .din_i            (din_i),
    .dout_o           (dout_o),
    .symb_clk_en_i    (symb_clk_en_i),
    .symb_clk_2x_en_i (symb_clk_2x_en_i),
    .symb_i_i         (symb_i_i),
    .symb_q_i         (symb_q_i),
    .dout_i_o         (dout_i_o),
    .dout_q_o         (dout_q_o),
    .cout_o           (cout_o),
    .symb_clk_o       (symb_clk_o),
    .fifo_rs_o        (fifo_rs_o),
    .clk_inv_o        (clk_inv_o),
    .bypass_fifo_o    (bypass_fifo_o)
  );

  initial
  begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // -------------------------------------------------------------------
  // reference models and checks
  // -------------------------------------------------------------------

  // nrz-m flags a change, nrz-s flags no change
  function automatic logic mark_space_bit(input logic [1:0] mode, input logic cur,
                                          input logic prev);
    if (mode == 2'd1)
      return cur ^ prev;
    else if (mode == 2'd2)
      return ~(cur ^ prev);
    return cur;
  endfunction

  task automatic check_bit(input string name, input logic got, input logic exp);
    assert (got === exp)
    else
    begin
      errors++;
      $display("Error: %s = %h, expected %h", name, got, exp);
    end
  endtask

  // -------------------------------------------------------------------
  // bus access
  // -------------------------------------------------------------------

  task automatic bus_write(input logic [12:0] addr, input logic [15:0] data,
                           input logic w0, input logic w1);
    @(negedge clk);
    en_i   = 1'b1;
    addr_i = addr;
    din_i  = data;
    wr0_i  = w0;
    wr1_i  = w1;
    @(negedge clk);
    en_i  = 1'b0;
    wr0_i = 1'b0;
    wr1_i = 1'b0;
  endtask

  task automatic read_check(input logic [12:0] addr, input logic en, input logic [15:0] exp);
    @(negedge clk);
    en_i   = en;
    addr_i = addr;
    #5;
    assert (dout_o === exp)
    else
    begin
      errors++;
      $display("Error: dout_o = %h, expected %h", dout_o, exp);
    end
    @(negedge clk);
    en_i = 1'b0;
  endtask

  // new configuration, history restarts
  task automatic start_test(input int new_kind);
    bus_write(decoder_pkg::dec_ctrl_addr, cfg.raw, 1'b1, 1'b1);
    kind = new_kind;
    hist_i.delete();
    hist_q.delete();
    msg.delete();
    cout_pulses = 0;
  endtask

  // -------------------------------------------------------------------
  // symbol stepping
  // -------------------------------------------------------------------

  // before the symbol edge, outputs still show the previous mid edge
  task automatic check_pre_symbol(input int j);
    logic ei;
    logic eq;
    case (kind)
      k_nrz:
      begin
        if (j >= 5)
        begin
          ei = mark_space_bit(cfg.fields.mode, hist_i[j-3], hist_i[j-4]);
          eq = mark_space_bit(cfg.fields.mode, hist_q[j-3], hist_q[j-4]);
          check_bit("dout_i_o", dout_i_o, cfg.fields.swap ? eq : ei);
          check_bit("dout_q_o", dout_q_o, cfg.fields.swap ? ei : eq);
        end
      end
      k_bip:
      begin
        // first half of each bit, three bits of latency
        if (j % 2 == 0)
        begin
          if (j >= 6)
            check_bit("dout_i_o", dout_i_o, hist_i[j-6]);
          if (j >= 2)
          begin
            assert (cout_pulses == 1)
            else
            begin
              errors++;
              $display("cout_o pulsed %0d times during one biphase bit", cout_pulses);
            end
          end
          cout_pulses = 0;
        end
      end
      k_qpsk:
      begin
        if (j >= 3)
          check_bit("dout_i_o", dout_i_o, hist_i[j-2]);
      end
      k_fqpsk:
      begin
        if (j >= 4)
          check_bit("dout_i_o", dout_i_o, hist_i[j-3] ^ hist_q[j-2]);
      end
      default:
      begin
        // derandomizer synced once 15 scrambled bits are in its line
        if (j >= 22)
        begin
          check_bit("dout_i_o", dout_i_o, msg[j-4] ^ cfg.fields.data_inv);
          check_bit("dout_q_o", dout_q_o, msg[j-4] ^ cfg.fields.data_inv);
        end
      end
    endcase
    if (j >= 2)
      check_bit("symb_clk_o", symb_clk_o, 1'b0);
  endtask

  // after the symbol edge, before the mid 2x edge
  task automatic check_pre_mid(input int j);
    if (kind == k_qpsk && j >= 3)
      check_bit("dout_i_o", dout_i_o, hist_q[j-2]);
    if (kind == k_fqpsk && j >= 3)
      check_bit("dout_i_o", dout_i_o, ~(hist_i[j-2] ^ hist_q[j-2]));
    if (j >= 1)
      check_bit("symb_clk_o", symb_clk_o, 1'b1);
  endtask

  task automatic send_symbol(input logic bi, input logic bq);
    int j;
    j = hist_i.size();
    for (int k = 0; k < 8; k++)
    begin
      @(negedge clk);
      symb_clk_en_i    = (k == 0);
      symb_clk_2x_en_i = (k == 0) || (k == 4);
      if (k == 0)
      begin
        symb_i_i = bi;
        symb_q_i = bq;
      end
      #5;
      if (cout_o)
        cout_pulses++;
      // strobe select outside biphase
      if (!cfg.fields.biphase)
        check_bit("cout_o", cout_o, cfg.fields.clk_sel ? symb_clk_en_i : symb_clk_2x_en_i);
      if (k == 0)
        check_pre_symbol(j);
      if (k == 4)
        check_pre_mid(j);
    end
    hist_i.push_back(bi);
    hist_q.push_back(bq);
  endtask

  task automatic send_random(input int n);
    logic [31:0] r;
    for (int i = 0; i < n; i++)
    begin
      r = $random(seed);
      send_symbol(r[0], r[1]);
    end
  endtask

  // scrambled with taps 15 and 14, message kept for the compare
  task automatic send_scrambled(input int n);
    logic [31:0] r;
    logic        s;
    int          j;
    for (int i = 0; i < n; i++)
    begin
      r = $random(seed);
      j = hist_i.size();
      s = r[0];
      if (j >= 15)
        s = s ^ hist_i[j-15];
      if (j >= 14)
        s = s ^ hist_i[j-14];
      msg.push_back(r[0]);
      send_symbol(s, r[1]);
    end
  endtask

  // -------------------------------------------------------------------
  // watchdog
  // -------------------------------------------------------------------

  initial
  begin
    #(timeout);
    $display("watchdog expired before the tests finished");
    $display("Simulation FAILED");
    $finish;
  end

  // -------------------------------------------------------------------
  // main sequence
  // -------------------------------------------------------------------

  initial
  begin
    logic [31:0] r;
    seed             = 32'h70c9_73e3;
    errors           = 0;
    kind             = k_nrz;
    cout_pulses      = 0;
    rs               = 1'b1;
    en_i             = 1'b0;
    wr0_i            = 1'b0;
    wr1_i            = 1'b0;
    addr_i           = '0;
    din_i            = '0;
    symb_clk_en_i    = 1'b0;
    symb_clk_2x_en_i = 1'b0;
    symb_i_i         = 1'b0;
    symb_q_i         = 1'b0;
    cfg.raw          = '0;
    repeat (2) @(negedge clk);
    rs = 1'b0;

    // register: each byte on its own strobe
    bus_write(decoder_pkg::dec_ctrl_addr, 16'h5503, 1'b1, 1'b0);
    read_check(decoder_pkg::dec_ctrl_addr, 1'b1, 16'h0003);
    bus_write(decoder_pkg::dec_ctrl_addr, 16'h10aa, 1'b0, 1'b1);
    read_check(decoder_pkg::dec_ctrl_addr, 1'b1, 16'h1003);
    read_check(decoder_pkg::dec_ctrl_addr ^ 13'h1, 1'b1, 16'h0000);
    read_check(decoder_pkg::dec_ctrl_addr, 1'b0, 16'h0000);
    check_bit("fifo_rs_o", fifo_rs_o, 1'b1);
    check_bit("clk_inv_o", clk_inv_o, 1'b1);
    check_bit("bypass_fifo_o", bypass_fifo_o, 1'b1);

    // nrz-l/m/s, straight and swapped
    for (int m = 0; m < 3; m++)
    begin
      for (int s = 0; s < 2; s++)
      begin
        cfg.raw            = '0;
        cfg.fields.mode    = 2'(m);
        cfg.fields.swap    = 1'(s);
        cfg.fields.clk_sel = 1'b1;
        start_test(k_nrz);
        send_random(10);
      end
    end

    // biphase-L, second half is the complement
    cfg.raw            = '0;
    cfg.fields.biphase = 1'b1;
    start_test(k_bip);
    for (int b = 0; b < 10; b++)
    begin
      r = $random(seed);
      send_symbol(r[0], r[1]);
      send_symbol(~r[0], r[2]);
    end

    // qpsk serial, then fqpsk
    cfg.raw          = '0;
    cfg.fields.demux = 1'b1;
    start_test(k_qpsk);
    send_random(12);
    cfg.raw          = '0;
    cfg.fields.feher = 1'b1;
    start_test(k_fqpsk);
    send_random(12);

    // derandomizer, then the same stream inverted
    cfg.raw                = '0;
    cfg.fields.derandomize = 1'b1;
    cfg.fields.clk_sel     = 1'b1;
    start_test(k_derand);
    send_scrambled(40);
    cfg.fields.data_inv = 1'b1;
    bus_write(decoder_pkg::dec_ctrl_addr, cfg.raw, 1'b1, 1'b1);
    send_scrambled(12);

    // cout_o on the 2x strobe
    cfg.raw = '0;
    start_test(k_nrz);
    send_random(4);

    total_fail = errors + u_dut.u_props.fail_cnt;
    $display("summary: %0d data errors, %0d assertion failures", errors,
             u_dut.u_props.fail_cnt);
    if (total_fail == 0)
    begin
      $display("Simulation PASSED");
    end
    else
    begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
